//--- hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // ************************************************************
    // Geometry
    // ************************************************************
    localparam int word_w     = 16;     // Data word and byte address
    localparam int tag_w      = 5;
    localparam int idx_w      = 8;
    localparam int off_w      = 3;      // Byte offset within a line
    localparam int line_words = 4;
    localparam int num_lines  = 256;
    localparam int mem_words  = 32768;
    localparam int mem_lat    = 2;      // Read latency in cycles

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [idx_w-1:0] idx;
        logic [off_w-1:0] off;
    } addr_fields_t;

    // Flat word for memory, fields for the array
    typedef union packed {
        logic [word_w-1:0] word;
        addr_fields_t      fields;
    } cache_addr_t;

    typedef enum logic [3:0] {
        idle, comp_rd, comp_wr,
        wb_0, wb_1, wb_2, wb_3,                         // Old line back to memory
        fill_0, fill_1, fill_2, fill_3, fill_4, fill_5, // Line refill
        done_st
    } cntrl_state_t;

endpackage

`default_nettype wire

//--- hdl/main_mem.sv
`default_nettype none

module main_mem (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  [cache_pkg::word_w-1:0]  addr_in_mem,
    input  wire  [cache_pkg::word_w-1:0]  data_in_mem,
    input  wire                           wrt_mem,
    input  wire                           rd_mem,
    output logic [cache_pkg::word_w-1:0]  data_out_mem
);
    import cache_pkg::*;

    // ************************************************************
    // Word array
    // ************************************************************
    logic [word_w-1:0]  mem [mem_words];
    logic [word_w-2:0]  mem_idx;         // Word index, byte bit dropped

    // Read pipeline, one slot per cycle of latency
    logic [word_w-1:0]  rd_pipe [mem_lat];
    logic [mem_lat-1:0] rd_vld;

    assign mem_idx = addr_in_mem[word_w-1:1];

    initial begin
        for (int i = 0; i < mem_words; i++)
            mem[i] = '0;
    end

    always @(posedge clk) begin
        if (wrt_mem)
            mem[mem_idx] <= data_in_mem;
    end

    // ************************************************************
    // Pipelined read
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rd_mem)
            rd_pipe[0] <= mem[mem_idx];
        for (int s = 1; s < mem_lat; s++)
            rd_pipe[s] <= rd_pipe[s-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_vld <= '0;
        else
            rd_vld <= {rd_vld[mem_lat-2:0], rd_mem};
    end

    // Idle bus reads zero
    assign data_out_mem = rd_vld[mem_lat-1] ? rd_pipe[mem_lat-1] : '0;

    // ************************************************************
    // Checks
    // ************************************************************
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_mem && wrt_mem));

endmodule

`default_nettype wire

//--- hdl/cache_array.sv
`default_nettype none

module cache_array (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           enable_cntrl,
    input  wire                           comp_cntrl,
    input  wire                           write_cntrl,
    input  wire                           valid_cntrl,
    input  wire  [cache_pkg::idx_w-1:0]   idx_cntrl,
    input  wire  [cache_pkg::off_w-1:0]   offset_cntrl,
    input  wire  [cache_pkg::tag_w-1:0]   tag_cntrl,
    input  wire  [cache_pkg::word_w-1:0]  data_in_cntrl,
    output logic                          hit_cache,
    output logic                          dirty_cache,
    output logic                          valid_cache,
    output logic [cache_pkg::tag_w-1:0]   tag_out,
    output logic [cache_pkg::word_w-1:0]  data_out_cache
);
    import cache_pkg::*;

    // ************************************************************
    // Storage
    // ************************************************************
    logic [tag_w-1:0]     tag_mem  [num_lines];
    logic [word_w-1:0]    data_mem [num_lines*line_words];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    cache_addr_t          loc;          // Array location of this access
    logic [idx_w+off_w-2:0] word_idx;
    logic                 tag_match;
    logic                 wr_en;

    always_comb begin
        loc.fields.tag = tag_cntrl;
        loc.fields.idx = idx_cntrl;
        loc.fields.off = offset_cntrl;
    end

    assign word_idx = loc.word[idx_w+off_w-1:1];      // Line and word, byte bit dropped

    // ************************************************************
    // Lookup
    // ************************************************************
    assign tag_out        = tag_mem[loc.fields.idx];
    assign valid_cache    = valid_bits[loc.fields.idx];
    assign dirty_cache    = dirty_bits[loc.fields.idx];
    assign data_out_cache = data_mem[word_idx];
    assign tag_match      = (tag_out == loc.fields.tag);
    assign hit_cache      = enable_cntrl && comp_cntrl && valid_cache && tag_match;

    // Compare writes only land on a hit
    assign wr_en = enable_cntrl && write_cntrl && (!comp_cntrl || hit_cache);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            if (comp_cntrl) begin
                dirty_bits[loc.fields.idx] <= 1'b1;
            end else begin
                valid_bits[loc.fields.idx] <= valid_cntrl;
                dirty_bits[loc.fields.idx] <= 1'b0;   // Fresh from memory
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !comp_cntrl)
            tag_mem[loc.fields.idx] <= loc.fields.tag;
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            data_mem[word_idx] <= data_in_cntrl;
    end

    // ************************************************************
    // Checks
    // ************************************************************
    a_write_enabled: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(write_cntrl) |-> enable_cntrl);

endmodule

`default_nettype wire

//--- hdl/cache_cntrl.sv
`default_nettype none

module cache_cntrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           rd,
    input  wire                           wr,
    input  wire  cache_pkg::cache_addr_t  addr,
    input  wire  [cache_pkg::word_w-1:0]  data_in,
    input  wire                           hit_cache,
    input  wire                           dirty_cache,
    input  wire                           valid_cache,
    input  wire  [cache_pkg::tag_w-1:0]   tag_out,
    input  wire  [cache_pkg::word_w-1:0]  data_out_cache,
    input  wire  [cache_pkg::word_w-1:0]  data_out_mem,
    output logic                          enable_cntrl,
    output logic                          comp_cntrl,
    output logic                          write_cntrl,
    output logic                          valid_cntrl,
    output logic [cache_pkg::idx_w-1:0]   idx_cntrl,
    output logic [cache_pkg::off_w-1:0]   offset_cntrl,
    output logic [cache_pkg::tag_w-1:0]   tag_cntrl,
    output logic [cache_pkg::word_w-1:0]  data_in_cntrl,
    output logic [cache_pkg::word_w-1:0]  addr_in_mem,
    output logic [cache_pkg::word_w-1:0]  data_in_mem,
    output logic                          wrt_mem,
    output logic                          rd_mem,
    output logic [cache_pkg::word_w-1:0]  data_out,
    output logic                          done,
    output logic                          stall,
    output logic                          cache_hit
);
    import cache_pkg::*;

    cntrl_state_t      state;
    cntrl_state_t      nxt_state;
    logic              hit_q;
    logic              write_q;
    logic              read_q;
    logic [word_w-1:0] data_q;
    logic [off_w-2:0]  mem_word;     // Word on the memory port
    logic [off_w-2:0]  inst_word;    // Word being installed
    logic [off_w-2:0]  req_word;
    logic              in_comp;
    logic              in_wb;
    logic              in_fill_rd;
    logic              in_fill_wr;
    logic              last_fill;
    logic              req_slot;

    // Builds a word-aligned line address through the field view
    function automatic cache_addr_t line_addr(input logic [tag_w-1:0] tag,
                                              input logic [idx_w-1:0] idx,
                                              input logic [off_w-2:0] word_sel);
        cache_addr_t a;
        a.fields.tag = tag;
        a.fields.idx = idx;
        a.fields.off = {word_sel, 1'b0};
        return a;
    endfunction

    // ************************************************************
    // State and request flags
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            hit_q   <= 1'b0;
            write_q <= 1'b0;
            read_q  <= 1'b0;
        end else begin
            state <= nxt_state;
            if (state == idle) begin
                read_q  <= rd;
                write_q <= wr & ~rd;
            end
            if (in_comp)
                hit_q <= hit_cache;
        end
    end

    always_ff @(posedge clk) begin
        if (in_comp)
            data_q <= data_out_cache;                 // Hit data
        else if (in_fill_wr && read_q && req_slot)
            data_q <= data_out_mem;                   // Requested word on refill
    end

    // ************************************************************
    // Next state and word sequencing
    // ************************************************************
    always_comb begin
        nxt_state = idle;
        mem_word  = '0;
        inst_word = '0;
        case (state)
            idle: begin
                if (rd)
                    nxt_state = comp_rd;
                else if (wr)
                    nxt_state = comp_wr;
            end
            comp_rd, comp_wr: begin
                if (hit_cache)
                    nxt_state = done_st;
                else if (valid_cache && dirty_cache)
                    nxt_state = wb_0;
                else
                    nxt_state = fill_0;
            end
            wb_0: nxt_state = wb_1;
            wb_1: begin
                mem_word  = 2'd1;
                nxt_state = wb_2;
            end
            wb_2: begin
                mem_word  = 2'd2;
                nxt_state = wb_3;
            end
            wb_3: begin
                mem_word  = 2'd3;
                nxt_state = fill_0;
            end
            fill_0: nxt_state = fill_1;
            fill_1: begin
                mem_word  = 2'd1;
                nxt_state = fill_2;
            end
            fill_2: begin
                mem_word  = 2'd2;                     // First word returns here
                nxt_state = fill_3;
            end
            fill_3: begin
                mem_word  = 2'd3;
                inst_word = 2'd1;
                nxt_state = fill_4;
            end
            fill_4: begin
                inst_word = 2'd2;
                nxt_state = fill_5;
            end
            fill_5: begin
                inst_word = 2'd3;
                nxt_state = idle;
            end
            default: nxt_state = idle;                // done_st
        endcase
    end

    assign in_comp    = state inside {comp_rd, comp_wr};
    assign in_wb      = state inside {wb_0, wb_1, wb_2, wb_3};
    assign in_fill_rd = state inside {fill_0, fill_1, fill_2, fill_3};
    assign in_fill_wr = state inside {fill_2, fill_3, fill_4, fill_5};
    assign last_fill  = (state == fill_5);
    assign req_word   = addr.fields.off[off_w-1:1];   // Bit 0 ignored
    assign req_slot   = (req_word == inst_word);

    // ************************************************************
    // Array side
    // ************************************************************
    assign enable_cntrl = in_comp | in_wb | in_fill_wr;
    assign comp_cntrl   = in_comp | (last_fill & write_q);  // Last word leaves line dirty
    assign write_cntrl  = (state == comp_wr) | in_fill_wr;
    assign valid_cntrl  = in_fill_wr;
    assign idx_cntrl    = addr.fields.idx;
    assign tag_cntrl    = addr.fields.tag;
    assign offset_cntrl = in_comp ? addr.fields.off : {(in_wb ? mem_word : inst_word), 1'b0};
    assign data_in_cntrl = (in_fill_wr && !(write_q && req_slot)) ? data_out_mem : data_in;

    // Memory side
    assign addr_in_mem = line_addr(in_wb ? tag_out : addr.fields.tag,
                                   addr.fields.idx, mem_word).word;
    assign data_in_mem = data_out_cache;
    assign wrt_mem     = in_wb;
    assign rd_mem      = in_fill_rd;

    // Requester side
    assign done      = (state == done_st) | last_fill;
    assign stall     = (state != idle);
    assign cache_hit = done & hit_q;
    assign data_out  = (last_fill && read_q && req_slot) ? data_out_mem : data_q;

    // ************************************************************
    // Checks
    // ************************************************************
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd && wr));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state) && (state <= done_st));

endmodule

`default_nettype wire

//--- hdl/cache_sys.sv
`default_nettype none

module cache_sys (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           rd,
    input  wire                           wr,
    input  wire  cache_pkg::cache_addr_t  addr,
    input  wire  [cache_pkg::word_w-1:0]  data_in,
    output logic [cache_pkg::word_w-1:0]  data_out,
    output logic                          done,
    output logic                          stall,
    output logic                          cache_hit
);
    import cache_pkg::*;

    // ************************************************************
    // Controller to array
    // ************************************************************
    logic              enable_cntrl;
    logic              comp_cntrl;
    logic              write_cntrl;
    logic              valid_cntrl;
    logic [idx_w-1:0]  idx_cntrl;
    logic [off_w-1:0]  offset_cntrl;
    logic [tag_w-1:0]  tag_cntrl;
    logic [word_w-1:0] data_in_cntrl;

    // Array status back to controller
    logic              hit_cache;
    logic              dirty_cache;
    logic              valid_cache;
    logic [tag_w-1:0]  tag_out;
    logic [word_w-1:0] data_out_cache;

    // ************************************************************
    // Controller to memory
    // ************************************************************
    logic [word_w-1:0] addr_in_mem;
    logic [word_w-1:0] data_in_mem;
    logic              wrt_mem;
    logic              rd_mem;
    logic [word_w-1:0] data_out_mem;   // Two cycles behind rd_mem

    // Port names match across the hierarchy
    cache_cntrl u_cntrl (
        .*
    );

    cache_array u_array (
        .*
    );

    main_mem u_mem (
        .*
    );

endmodule

`default_nettype wire

//--- verification/cache_checker.sv
`default_nettype none

module cache_checker (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           rd,
    input  wire                           wr,
    input  wire  [cache_pkg::word_w-1:0]  addr,
    input  wire  [cache_pkg::word_w-1:0]  data_in,
    input  wire  [cache_pkg::word_w-1:0]  data_out,
    input  wire                           done,
    input  wire                           stall,
    input  wire                           cache_hit,
    input  wire  [8*16-1:0]               test_name,
    input  wire                           use_exp,     // Table values present
    input  wire                           exp_hit,
    input  wire  [cache_pkg::word_w-1:0]  exp_data,
    output int                            err_count,
    output int                            check_count
);
    import cache_pkg::*;

    // ************************************************************
    // Reference model
    // ************************************************************
    logic [word_w-1:0]    mem_model [mem_words];   // Last written value per word
    logic [tag_w-1:0]     tag_model [num_lines];
    logic [num_lines-1:0] valid_model;
    logic [tag_w-1:0]     a_tag;
    logic [idx_w-1:0]     a_idx;
    logic [word_w-2:0]    a_word;
    logic                 model_hit;
    logic                 busy;                    // Request accepted, done not yet seen
    logic                 done_q;
    int                   errors = 0;
    int                   checks = 0;

    assign a_tag     = addr[word_w-1 -: tag_w];
    assign a_idx     = addr[off_w +: idx_w];
    assign a_word    = addr[word_w-1:1];           // Byte bit ignored
    assign model_hit = valid_model[a_idx] && (tag_model[a_idx] == a_tag);

    assign err_count   = errors;
    assign check_count = checks;

    initial begin
        for (int i = 0; i < mem_words; i++)
            mem_model[i] = '0;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s %s expected 0x%0h actual 0x%0h", test_name, what,
                     expected, actual);
        end
    endtask

    // ************************************************************
    // Protocol and result checks
    // ************************************************************
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            done_q      <= 1'b0;
            valid_model <= '0;
        end else begin
            done_q <= done;
            if (stall !== busy) begin
                errors++;
                $display("stall was %b while a request in progress was %b", stall, busy);
            end
            if (done && done_q) begin
                errors++;
                $display("done stayed high for more than one cycle in %s", test_name);
            end
            if (done && !busy) begin
                errors++;
                $display("done rose while no request was in progress");
            end
            if (done) begin
                checks++;
                check_value("hit", model_hit, cache_hit);
                if (rd)
                    check_value("data", mem_model[a_word], data_out);
                if (use_exp) begin
                    check_value("table hit", exp_hit, cache_hit);
                    if (rd)
                        check_value("table data", exp_data, data_out);
                end
                if (wr)
                    mem_model[a_word] <= data_in;
                tag_model[a_idx]   <= a_tag;
                valid_model[a_idx] <= 1'b1;        // Line resident after any access
                busy <= 1'b0;
            end else if (!busy && (rd || wr)) begin
                busy <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/cache_sys_tb.sv
`default_nettype none

module cache_sys_tb;
    import cache_pkg::*;

    localparam int n_steps    = 18;
    localparam int n_random   = 40;
    localparam int max_cycles = (n_steps + n_random) * 11 + 50;

    logic              clk;
    logic              rst_n;
    logic              rd;
    logic              wr;
    logic [word_w-1:0] addr;
    logic [word_w-1:0] data_in;
    logic [word_w-1:0] data_out;
    logic              done;
    logic              stall;
    logic              cache_hit;
    logic [8*16-1:0]   test_name;
    logic              use_exp;
    logic              exp_hit;
    logic [word_w-1:0] exp_data;
    int                err_count;
    int                check_count;
    int                cycles;
    int                n_added;
    logic [31:0]       lcg_state;

    // ************************************************************
    // Stimulus table
    // ************************************************************
    logic [8*16-1:0]   step_name  [n_steps];
    logic              step_wr    [n_steps];
    logic [word_w-1:0] step_addr  [n_steps];
    logic [word_w-1:0] step_data  [n_steps];
    logic              step_hit   [n_steps];
    logic [word_w-1:0] step_rdata [n_steps];

    cache_sys uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    cache_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd          (rd),
        .wr          (wr),
        .addr        (addr),
        .data_in     (data_in),
        .data_out    (data_out),
        .done        (done),
        .stall       (stall),
        .cache_hit   (cache_hit),
        .test_name   (test_name),
        .use_exp     (use_exp),
        .exp_hit     (exp_hit),
        .exp_data    (exp_data),
        .err_count   (err_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("Simulation failed");
        $finish;
    end

    // Tag, index and word to a byte address
    function automatic logic [word_w-1:0] make_addr(input int tag, input int idx,
                                                    input int word);
        return {tag[tag_w-1:0], idx[idx_w-1:0], word[1:0], 1'b0};
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_step(input logic [8*16-1:0] name, input logic is_wr, input int tag,
                            input int idx, input int word, input logic [word_w-1:0] d,
                            input logic hit, input logic [word_w-1:0] rdata);
        step_name[n_added]  = name;
        step_wr[n_added]    = is_wr;
        step_addr[n_added]  = make_addr(tag, idx, word);
        step_data[n_added]  = d;
        step_hit[n_added]   = hit;
        step_rdata[n_added] = rdata;
        n_added++;
    endtask

    // Called just after a rising edge, returns just after one
    task automatic run_request(input logic [8*16-1:0] name, input logic is_wr,
                               input logic [word_w-1:0] a, input logic [word_w-1:0] d,
                               input logic chk, input logic hit,
                               input logic [word_w-1:0] rdata);
        test_name = name;
        use_exp   = chk;
        exp_hit   = hit;
        exp_data  = rdata;
        addr      = a;
        data_in   = d;
        rd        = !is_wr;
        wr        = is_wr;
        @(negedge clk);
        while (!done)
            @(negedge clk);
        @(posedge clk);
        #1;
        rd = 1'b0;                                 // Drop in the cycle after done
        wr = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // ************************************************************
    // Main sequence
    // ************************************************************
    initial begin
        logic              r_wr;
        logic [word_w-1:0] r_addr;
        logic [word_w-1:0] r_data;

        rst_n     = 1'b0;
        rd        = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        data_in   = '0;
        test_name = "reset";
        use_exp   = 1'b0;
        exp_hit   = 1'b0;
        exp_data  = '0;
        lcg_state = 32'd2;
        n_added   = 0;

        add_step("rd_cold",       1'b0, 1,  5, 0, 16'h0000, 1'b0, 16'h0000);
        add_step("rd_again",      1'b0, 1,  5, 2, 16'h0000, 1'b1, 16'h0000);
        add_step("wr_miss",       1'b1, 2,  9, 1, 16'ha5a5, 1'b0, 16'h0000);
        add_step("rd_wr_word",    1'b0, 2,  9, 1, 16'h0000, 1'b1, 16'ha5a5);
        add_step("rd_word0",      1'b0, 2,  9, 0, 16'h0000, 1'b1, 16'h0000);
        add_step("rd_word3",      1'b0, 2,  9, 3, 16'h0000, 1'b1, 16'h0000);
        add_step("wr_dirty_a",    1'b1, 3, 20, 2, 16'h1234, 1'b0, 16'h0000);
        add_step("rd_evict_b",    1'b0, 7, 20, 2, 16'h0000, 1'b0, 16'h0000);
        add_step("rd_back_a",     1'b0, 3, 20, 2, 16'h0000, 1'b0, 16'h1234);
        add_step("rd_clean",      1'b0, 4, 33, 3, 16'h0000, 1'b0, 16'h0000);
        add_step("wr_hit",        1'b1, 4, 33, 3, 16'hbeef, 1'b1, 16'h0000);
        add_step("rd_evict",      1'b0, 6, 33, 3, 16'h0000, 1'b0, 16'h0000);
        add_step("rd_newer",      1'b0, 4, 33, 3, 16'h0000, 1'b0, 16'hbeef);
        add_step("wr_hit2",       1'b1, 4, 33, 0, 16'h0f0f, 1'b1, 16'h0000);
        add_step("rd_after",      1'b0, 4, 33, 0, 16'h0000, 1'b1, 16'h0f0f);
        add_step("wr_dirty_miss", 1'b1, 9, 33, 1, 16'h7777, 1'b0, 16'h0000);
        add_step("rd_old_line",   1'b0, 4, 33, 0, 16'h0000, 1'b0, 16'h0f0f);
        add_step("rd_w_line",     1'b0, 9, 33, 1, 16'h0000, 1'b0, 16'h7777);

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        for (int i = 0; i < n_steps; i++)
            run_request(step_name[i], step_wr[i], step_addr[i], step_data[i], 1'b1,
                        step_hit[i], step_rdata[i]);

        // Two tags over four indices, so lines keep evicting each other
        for (int i = 0; i < n_random; i++) begin
            lcg_state = next_rand(lcg_state);
            r_wr      = lcg_state[31];
            r_addr    = make_addr(lcg_state[30] ? 2 : 1, 64 + lcg_state[29:28],
                                  lcg_state[27:26]);
            lcg_state = next_rand(lcg_state);
            r_data    = lcg_state[31:16];
            run_request("random", r_wr, r_addr, r_data, 1'b0, 1'b0, '0);
        end

        repeat (2) @(posedge clk);
        $display("Requests checked %0d of %0d, errors %0d", check_count,
                 n_steps + n_random, err_count);
        if (check_count != n_steps + n_random)
            $display("Not every request completed with a done pulse");
        if (err_count == 0 && check_count == n_steps + n_random)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_sys.f
hdl/cache_pkg.sv
hdl/main_mem.sv
hdl/cache_array.sv
hdl/cache_cntrl.sv
hdl/cache_sys.sv
verification/cache_checker.sv
verification/cache_sys_tb.sv
